//--- verilog/exec_pkg.sv
`default_nettype none

package exec_pkg;

    typedef enum logic [2:0] {
        OP_LDI = 3'd0,  // load sign-extended imm8
        OP_MOV = 3'd1,
        OP_ADD = 3'd2,
        OP_SUB = 3'd3,
        OP_AND = 3'd4,
        OP_OR  = 3'd5,
        OP_XOR = 3'd6,
        OP_CMP = 3'd7   // subtract, flags only
    } op_e;

    // code 3 is decoded as a long
    typedef enum logic [1:0] {
        SZ_B = 2'd0,
        SZ_W = 2'd1,
        SZ_L = 2'd2
    } size_e;

    typedef union packed {
        struct packed {
            size_e      size;
            op_e        op;
            logic [2:0] dst;
            logic [7:0] imm8;
        } imm;
        struct packed {
            size_e      size;
            op_e        op;
            logic [2:0] dst;
            logic [2:0] src;
            logic       zx;     // zero-extend the source
            logic [3:0] rsvd;
        } rg;
    } instr_u;

    // flag byte layout, bits 5 and 3 read as zero
    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_H = 4;
    localparam int FLAG_V = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 0;

    localparam logic [7:0] DMP_FLAGS_ADDR = 8'h20;

endpackage

`default_nettype wire

//--- verilog/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode
    import exec_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        instr_valid,
    input  instr_u      instr,
    output logic        d_valid,
    output op_e         d_op,
    output size_e       d_size,
    output logic [2:0]  d_dst,
    output logic [2:0]  d_src,
    output logic        d_zx,
    output logic [31:0] d_imm
);

    logic  is_ldi;
    size_e size_dec;

    assign is_ldi = (instr.imm.op == OP_LDI);

    always_comb begin
        case (instr.imm.size)
            SZ_B:    size_dec = SZ_B;
            SZ_W:    size_dec = SZ_W;
            default: size_dec = SZ_L;  // fourth code folds into long
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            d_op   <= instr.imm.op;
            d_size <= size_dec;
            d_dst  <= instr.imm.dst;
            if (is_ldi) begin
                d_imm <= {{24{instr.imm.imm8[7]}}, instr.imm.imm8};  // imm view
                d_src <= 3'd0;
                d_zx  <= 1'b0;
            end else begin
                d_imm <= 32'd0;
                d_src <= instr.rg.src;  // reg view
                d_zx  <= instr.rg.zx;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fetch
    import exec_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        d_valid,
    input  op_e         d_op,
    input  size_e       d_size,
    input  logic [2:0]  d_dst,
    input  logic [2:0]  d_src,
    input  logic        d_zx,
    input  logic [31:0] d_imm,
    output logic [2:0]  rd_addr_a,
    output logic [2:0]  rd_addr_b,
    input  logic [31:0] rd_data_a,
    input  logic [31:0] rd_data_b,
    input  logic        fwd_valid,
    input  logic [2:0]  fwd_dst,
    input  logic [31:0] fwd_data,
    output logic        o_valid,
    output op_e         o_op,
    output size_e       o_size,
    output logic [2:0]  o_dst,
    output logic [31:0] o_old,
    output logic [31:0] o_a,
    output logic [31:0] o_b
);

    logic [2:0]  src_q;
    logic        zx_q;
    logic [31:0] imm_q;
    logic [31:0] src_full;
    logic [31:0] src_ext;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (d_valid) begin
            o_op   <= d_op;
            o_size <= d_size;
            o_dst  <= d_dst;
            src_q  <= d_src;
            zx_q   <= d_zx;
            imm_q  <= d_imm;
        end
    end

    // registered addresses, so the instruction ahead is already in E
    assign rd_addr_a = o_dst;
    assign rd_addr_b = src_q;
    assign o_old    = (fwd_valid && fwd_dst == o_dst) ? fwd_data : rd_data_a;
    assign src_full = (fwd_valid && fwd_dst == src_q) ? fwd_data : rd_data_b;

    always_comb begin
        case (o_size)
            SZ_B: begin
                o_a     = {24'd0, o_old[7:0]};
                src_ext = zx_q ? {24'd0, src_full[7:0]} : {{24{src_full[7]}}, src_full[7:0]};
            end
            SZ_W: begin
                o_a     = {16'd0, o_old[15:0]};
                src_ext = zx_q ? {16'd0, src_full[15:0]}
                               : {{16{src_full[15]}}, src_full[15:0]};
            end
            default: begin
                o_a     = o_old;
                src_ext = src_full;
            end
        endcase
        o_b = (o_op == OP_LDI) ? imm_q : src_ext;  // immediate replaces source
    end

endmodule

`default_nettype wire

//--- verilog/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit
    import exec_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        o_valid,
    input  op_e         o_op,
    input  size_e       o_size,
    input  logic [2:0]  o_dst,
    input  logic [31:0] o_old,
    input  logic [31:0] o_a,
    input  logic [31:0] o_b,
    input  logic [7:0]  flags_in,
    output logic        e_valid,
    output logic        e_we,
    output logic [2:0]  e_dst,
    output logic [31:0] e_data,
    output logic        e_flags_we,
    output logic [7:0]  e_flags
);

    logic [31:0] mask;
    logic [4:0]  msb;       // sign bit at this size
    logic [31:0] b_sz;
    logic [32:0] arith;
    logic [4:0]  half;
    logic [31:0] res;
    logic        is_sub;
    logic        v_out;
    logic [7:0]  cur_flags;
    logic [7:0]  new_flags;

    assign is_sub    = (o_op == OP_SUB) || (o_op == OP_CMP);
    assign b_sz      = o_b & mask;
    assign cur_flags = (e_valid && e_flags_we) ? e_flags : flags_in;  // newest flags
    assign arith     = is_sub ? {1'b0, o_a} - {1'b0, b_sz} : {1'b0, o_a} + {1'b0, b_sz};
    assign half      = is_sub ? {1'b0, o_a[3:0]} - {1'b0, b_sz[3:0]}
                              : {1'b0, o_a[3:0]} + {1'b0, b_sz[3:0]};
    assign v_out     = is_sub ? (o_a[msb] != b_sz[msb]) && (arith[msb] != o_a[msb])
                              : (o_a[msb] == b_sz[msb]) && (arith[msb] != o_a[msb]);

    always_comb begin
        case (o_size)
            SZ_B: begin
                mask = 32'h0000_00ff;
                msb  = 5'd7;
            end
            SZ_W: begin
                mask = 32'h0000_ffff;
                msb  = 5'd15;
            end
            default: begin
                mask = 32'hffff_ffff;
                msb  = 5'd31;
            end
        endcase
        case (o_op)
            OP_LDI, OP_MOV: res = o_b;
            OP_AND:         res = o_a & b_sz;
            OP_OR:          res = o_a | b_sz;
            OP_XOR:         res = o_a ^ b_sz;
            default:        res = arith[31:0];
        endcase
        new_flags = cur_flags;  // LDI and MOV keep the flags
        case (o_op)
            OP_ADD, OP_SUB, OP_CMP: begin
                new_flags         = 8'h00;
                new_flags[FLAG_S] = res[msb];
                new_flags[FLAG_Z] = (res & mask) == 32'd0;
                new_flags[FLAG_H] = half[4];  // carry or borrow out of bit 3
                new_flags[FLAG_V] = v_out;
                new_flags[FLAG_N] = is_sub;
                new_flags[FLAG_C] = arith[msb + 6'd1];
            end
            OP_AND, OP_OR, OP_XOR: begin
                new_flags         = 8'h00;
                new_flags[FLAG_S] = res[msb];
                new_flags[FLAG_Z] = (res & mask) == 32'd0;
                new_flags[FLAG_H] = (o_op == OP_AND);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            e_valid    <= 1'b0;
            e_we       <= 1'b0;
            e_flags_we <= 1'b0;
        end else begin
            e_valid    <= o_valid;
            e_we       <= o_valid && (o_op != OP_CMP);
            e_flags_we <= o_valid && (o_op != OP_LDI) && (o_op != OP_MOV);
        end
    end

    always_ff @(posedge clk) begin
        if (o_valid) begin
            e_dst   <= o_dst;
            e_data  <= (o_old & ~mask) | (res & mask);  // keep bits above the size
            e_flags <= new_flags;
        end
    end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import exec_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [2:0]  rd_addr_a,
    input  logic [2:0]  rd_addr_b,
    output logic [31:0] rd_data_a,
    output logic [31:0] rd_data_b,
    input  logic        e_valid,
    input  logic        e_we,
    input  logic [2:0]  e_dst,
    input  logic [31:0] e_data,
    input  logic        e_flags_we,
    input  logic [7:0]  e_flags,
    output logic        retire,
    output logic [7:0]  flags,
    input  logic [7:0]  dmp_addr,
    output logic [7:0]  dmp_dout
);

    logic [31:0] regs [8];
    logic [31:0] dmp_word;

    // the writeback edge closes this cycle
    assign retire = e_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= 32'd0;
            end
            flags <= 8'h00;
        end else begin
            if (e_valid && e_we) begin
                regs[e_dst] <= e_data;  // already merged to the full register
            end
            if (e_valid && e_flags_we) begin
                flags <= e_flags;
            end
        end
    end

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    // dump port, does not touch the pipeline
    assign dmp_word = regs[dmp_addr[4:2]];

    always_comb begin
        if (dmp_addr == DMP_FLAGS_ADDR) begin
            dmp_dout = flags;
        end else if (dmp_addr[7:5] != 3'd0) begin
            dmp_dout = 8'h00;  // unmapped
        end else begin
            dmp_dout = dmp_word[{dmp_addr[1:0], 3'b000} +: 8];  // byte lane
        end
    end

endmodule

`default_nettype wire

//--- verilog/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top
    import exec_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       instr_valid,
    input  instr_u     instr,
    output logic       retire,
    output logic [7:0] flags,
    input  logic [7:0] dmp_addr,
    output logic [7:0] dmp_dout
);

    logic        d_valid;
    op_e         d_op;
    size_e       d_size;
    logic [2:0]  d_dst;
    logic [2:0]  d_src;
    logic        d_zx;
    logic [31:0] d_imm;
    logic [2:0]  rd_addr_a;
    logic [2:0]  rd_addr_b;
    logic [31:0] rd_data_a;
    logic [31:0] rd_data_b;
    logic        o_valid;
    op_e         o_op;
    size_e       o_size;
    logic [2:0]  o_dst;
    logic [31:0] o_old;
    logic [31:0] o_a;
    logic [31:0] o_b;
    logic        e_valid;
    logic        e_we;
    logic [2:0]  e_dst;
    logic [31:0] e_data;
    logic        e_flags_we;
    logic [7:0]  e_flags;

    instr_decode u_decode (.*);

    // E-stage result is the only bypass source
    operand_fetch u_fetch (
        .fwd_valid (e_we),
        .fwd_dst   (e_dst),
        .fwd_data  (e_data),
        .*
    );

    alu_unit u_alu (
        .flags_in (flags),
        .*
    );

    reg_file u_regs (.*);

endmodule

`default_nettype wire

//--- dv/exec_props.sv
`timescale 1ns/1ps
`default_nettype none

module exec_props (
    input logic       clk,
    input logic       rst,
    input logic       instr_valid,
    input logic       retire,
    input logic       e_we,
    input logic [2:0] e_dst,
    input logic [7:0] dmp_addr,
    input logic [7:0] dmp_dout
);

    // fixed depth, no stalls
    retire_latency: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> ##3 retire)
        else $error("retire missing three cycles after instr_valid");

    retire_source: assert property (@(posedge clk) disable iff (rst)
        retire |-> $past(instr_valid, 3))
        else $error("retire without an instruction three cycles earlier");

    // a retire with e_we low is a CMP
    cmp_keeps_dst: assert property (@(posedge clk) disable iff (rst)
        retire && !e_we && dmp_addr[7:5] == 3'd0 && dmp_addr[4:2] == e_dst
        |=> !$stable(dmp_addr) || $stable(dmp_dout))
        else $error("CMP changed its destination register");

    no_retire_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !retire)
        else $error("retire high in the first cycle after reset");

endmodule

bind exec_top exec_props u_props (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .retire      (retire),
    .e_we        (e_we),
    .e_dst       (e_dst),
    .dmp_addr    (dmp_addr),
    .dmp_dout    (dmp_dout)
);

`default_nettype wire

//--- dv/exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_tb
    import exec_pkg::*;
();

    logic        clk;
    logic        rst;
    logic        instr_valid;
    instr_u      instr;
    logic        retire;
    logic [7:0]  flags;
    logic [7:0]  dmp_addr;
    logic [7:0]  dmp_dout;

    logic [31:0] model_regs [8];
    logic [7:0]  model_flags;
    logic [7:0]  exp_flags_q [$];  // one entry per strobe in issue order
    integer      seed = 56916;
    int          n_issued;
    int          n_retired;
    int          n_checks;
    int          n_errors;
    logic        timed_out;
    string       test_name;

    exec_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .retire      (retire),
        .flags       (flags),
        .dmp_addr    (dmp_addr),
        .dmp_dout    (dmp_dout)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] mk_imm(input logic [1:0] sz, input op_e op,
                                           input logic [2:0] dst, input logic [7:0] imm8);
        return {sz, op, dst, imm8};
    endfunction

    function automatic logic [15:0] mk_reg(input logic [1:0] sz, input op_e op,
                                           input logic [2:0] dst, input logic [2:0] src,
                                           input logic zx);
        return {sz, op, dst, src, zx, 4'b1010};  // reserved bits are don't care
    endfunction

    // sequential reference model applying one instruction at a time
    function automatic void exec_model(input logic [15:0] iw);
        op_e         op;
        int          w;
        logic [2:0]  dst;
        logic [31:0] mask;
        logic [31:0] sbit;
        logic [31:0] old;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic        sub;
        logic [7:0]  f;
        op   = op_e'(iw[13:11]);
        dst  = iw[10:8];
        w    = (iw[15:14] == 2'd0) ? 8 : (iw[15:14] == 2'd1) ? 16 : 32;
        mask = (w == 32) ? 32'hffff_ffff : (32'd1 << w) - 32'd1;
        sbit = 32'd1 << (w - 1);
        old  = model_regs[dst];
        a    = old & mask;
        b    = model_regs[iw[7:5]];
        if (op == OP_LDI) begin
            b = {{24{iw[7]}}, iw[7:0]};
        end else if (!iw[4]) begin
            b = ((b & mask) ^ sbit) - sbit;  // sign extend from the size
        end
        b   = b & mask;
        sub = (op == OP_SUB) || (op == OP_CMP);
        case (op)
            OP_LDI, OP_MOV: r = b;
            OP_AND:         r = a & b;
            OP_OR:          r = a | b;
            OP_XOR:         r = a ^ b;
            default:        r = sub ? a - b : a + b;
        endcase
        r = r & mask;
        f = model_flags;
        if (op inside {OP_ADD, OP_SUB, OP_CMP}) begin
            f         = 8'h00;
            f[FLAG_C] = sub ? (a < b) : ({1'b0, a} + {1'b0, b} > {1'b0, mask});
            f[FLAG_H] = sub ? (a[3:0] < b[3:0]) : ({1'b0, a[3:0]} + {1'b0, b[3:0]} > 5'd15);
            f[FLAG_V] = sub ? (a[w-1] != b[w-1]) && (r[w-1] != a[w-1])
                            : (a[w-1] == b[w-1]) && (r[w-1] != a[w-1]);
            f[FLAG_N] = sub;
        end else if (op inside {OP_AND, OP_OR, OP_XOR}) begin
            f         = 8'h00;
            f[FLAG_H] = (op == OP_AND);
        end
        if (op != OP_LDI && op != OP_MOV) begin
            f[FLAG_S] = r[w-1];
            f[FLAG_Z] = (r == 32'd0);
        end
        if (op != OP_CMP) begin
            model_regs[dst] = (old & ~mask) | r;
        end
        model_flags = f;
    endfunction

    task automatic compare(input string what, input logic [31:0] expv, input logic [31:0] actv);
        n_checks++;
        if (actv !== expv) begin
            n_errors++;
            $display("ERR %s %s expected %h actual %h", test_name, what, expv, actv);
        end
    endtask

    task automatic issue_instr(input logic [15:0] iw);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = iw;
        exec_model(iw);
        exp_flags_q.push_back(model_flags);
        n_issued++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    task automatic drain_pipeline();
        int waited;
        idle_cycles(1);
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (n_retired != n_issued && waited < 50);
        if (n_retired != n_issued) begin
            n_errors++;
            timed_out = 1'b1;
            $display("timeout in %s, retire never came for %0d instructions",
                     test_name, n_issued - n_retired);
        end
        @(negedge clk);  // writeback of the last one now visible
    endtask

    task automatic dump_all();
        logic [7:0] addr;
        logic [7:0] expv;
        for (int i = 0; i < 35; i++) begin
            addr = (i == 34) ? 8'he3 : 8'(i);
            if (i < 32) begin
                expv = 8'(model_regs[i / 4] >> (8 * (i % 4)));
            end else begin
                expv = (i == 32) ? model_flags : 8'h00;  // 0x21 and 0xe3 unmapped
            end
            @(negedge clk);
            dmp_addr = addr;
            @(posedge clk);
            compare($sformatf("dump %h", addr), expv, dmp_dout);
        end
        @(negedge clk);
        dmp_addr = 8'h00;
    endtask

    task automatic load_pow2(input logic [2:0] r, input int n);
        issue_instr(mk_imm(SZ_L, OP_LDI, r, 8'h01));
        repeat (n) issue_instr(mk_reg(SZ_L, OP_ADD, r, r, 1'b0));
    endtask

    // each size and op over all pairs of r0..r6 with r7 as scratch unless CMP
    task automatic sweep_ops(input logic [2:0] first_op, input int n_ops);
        op_e op;
        for (int s = 0; s < 3; s++) begin
            for (int k = 0; k < n_ops; k++) begin
                op = op_e'(first_op + 3'(k));
                for (int x = 0; x < 7; x++) begin
                    for (int y = 0; y < 7; y++) begin
                        if (op == OP_CMP) begin
                            issue_instr(mk_reg(2'(s), op, 3'(x), 3'(y), 1'(x ^ y)));
                        end else begin
                            issue_instr(mk_reg(SZ_L, OP_MOV, 3'd7, 3'(x), 1'b0));
                            issue_instr(mk_reg(2'(s), op, 3'd7, 3'(y), 1'(x ^ y)));
                        end
                    end
                end
            end
        end
    endtask

    task automatic run_test(input int t);
        int g;
        case (t)
            1: begin
                test_name = "ldi_widths";
                for (int r = 0; r < 8; r++) begin
                    issue_instr(mk_imm((r == 7) ? 2'd3 : SZ_L, OP_LDI, 3'(r), 8'(r * 37)));
                    issue_instr(mk_imm(SZ_W, OP_LDI, 3'(r), 8'(240 - r * 19)));
                    if (r % 2 == 1) begin
                        issue_instr(mk_imm(SZ_B, OP_LDI, 3'(r), 8'(r * 59 + 17)));
                    end
                end
            end
            2: begin
                test_name = "fwd_chain";
                issue_instr(mk_imm(SZ_L, OP_LDI, 3'd1, 8'h35));
                issue_instr(mk_imm(SZ_L, OP_LDI, 3'd2, 8'h81));
                for (int i = 0; i < 16; i++) begin
                    issue_instr(mk_reg(2'(i % 3), OP_ADD, 3'd1, 3'd2, 1'b0));
                    issue_instr(mk_reg(2'(i % 3), OP_ADD, 3'd1, 3'd1, 1'b0));
                    issue_instr(mk_reg(2'(i % 3), OP_SUB, 3'd2, 3'd1, 1'b1));
                    issue_instr(mk_reg(2'((i + 1) % 3), OP_SUB, 3'd3, 3'd2, 1'b0));
                end
            end
            3: begin
                test_name = "edge_arith";
                issue_instr(mk_imm(SZ_L, OP_LDI, 3'd0, 8'h7f));
                issue_instr(mk_imm(SZ_L, OP_LDI, 3'd1, 8'h01));
                load_pow2(3'd2, 15);  // 0x8000
                load_pow2(3'd3, 15);
                issue_instr(mk_reg(SZ_L, OP_SUB, 3'd3, 3'd1, 1'b0));  // 0x7fff
                load_pow2(3'd4, 31);
                load_pow2(3'd5, 31);
                issue_instr(mk_reg(SZ_L, OP_SUB, 3'd5, 3'd1, 1'b0));
                issue_instr(mk_imm(SZ_L, OP_LDI, 3'd1, 8'h80));  // 0xffffff80
                issue_instr(mk_imm(SZ_L, OP_LDI, 3'd6, 8'hff));
                sweep_ops(3'(OP_ADD), 2);
            end
            4: begin
                test_name = "logic_cmp";
                sweep_ops(3'(OP_AND), 4);
            end
            5: begin
                test_name = "mov_ext";
                for (int s = 0; s < 2; s++) begin
                    for (int zx = 0; zx < 2; zx++) begin
                        for (int y = 0; y < 7; y++) begin
                            issue_instr(mk_reg(2'(s), OP_MOV, 3'(7 - y), 3'(y), 1'(zx)));
                        end
                        drain_pipeline();
                        if (!timed_out) begin
                            dump_all();
                        end
                    end
                end
            end
            default: begin
                test_name = "random";
                for (int i = 0; i < 300; i++) begin
                    issue_instr(16'($random(seed)));
                    g = $unsigned($random(seed)) % 4;
                    if (g >= 2) begin
                        idle_cycles(g - 1);  // otherwise back to back
                    end
                end
            end
        endcase
        drain_pipeline();
        if (!timed_out) begin
            dump_all();
        end
    endtask

    // flags must match the model four rising edges after each strobe
    initial begin : flag_check
        logic [3:0] age;
        age = 4'd0;
        forever begin
            @(posedge clk);
            age = rst ? 4'd0 : {age[2:0], instr_valid};
            if (age[3]) begin
                @(negedge clk);
                if (exp_flags_q.size() == 0) begin
                    n_errors++;
                    $display("flag check in %s found no expected value queued", test_name);
                end else begin
                    compare("flags", exp_flags_q.pop_front(), flags);
                end
            end
        end
    end

    initial begin : retire_count
        forever begin
            @(negedge clk);
            if (retire) begin
                n_retired++;
            end
        end
    end

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        dmp_addr    = 8'h00;
        model_flags = 8'h00;
        n_issued    = 0;
        n_retired   = 0;
        n_checks    = 0;
        n_errors    = 0;
        timed_out   = 1'b0;
        test_name   = "reset";
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = 32'd0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int t = 1; t <= 6 && !timed_out; t++) begin
            run_test(t);
        end
        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
verilog/exec_pkg.sv
verilog/instr_decode.sv
verilog/operand_fetch.sv
verilog/alu_unit.sv
verilog/reg_file.sv
verilog/exec_top.sv
dv/exec_props.sv
dv/exec_tb.sv

//--- Bender.yml
package:
  name: exec_pipe

sources:
  - verilog/exec_pkg.sv
  - verilog/instr_decode.sv
  - verilog/operand_fetch.sv
  - verilog/alu_unit.sv
  - verilog/reg_file.sv
  - verilog/exec_top.sv
  - target: test
    files:
      - dv/exec_props.sv
      - dv/exec_tb.sv
